// File: src/conf_pkg.sv
package conf_pkg;

   // control bus
   localparam int DATA_W      = 32;
   localparam int CONF_ADDR_W = 6;

   // engine geometry
   localparam int N_UNITS     = 4;
   localparam int N_FIELDS    = 4;
   localparam int UNIT_IDX_W  = $clog2(N_UNITS);
   localparam int FIELD_IDX_W = $clog2(N_FIELDS);

   // field widths, taken from the low bits of a data word
   localparam int SEL_W   = 5;
   localparam int FNS_W   = 4;
   localparam int DELAY_W = 5;

   // field index inside one unit
   localparam logic [FIELD_IDX_W-1:0] FLD_SEL_A = FIELD_IDX_W'(0);
   localparam logic [FIELD_IDX_W-1:0] FLD_SEL_B = FIELD_IDX_W'(1);
   localparam logic [FIELD_IDX_W-1:0] FLD_FNS   = FIELD_IDX_W'(2);
   localparam logic [FIELD_IDX_W-1:0] FLD_DELAY = FIELD_IDX_W'(3);

   // address map
   // field address = unit * N_FIELDS + field, clear sits right above the fields
   localparam logic [CONF_ADDR_W-1:0] CONF_CLEAR = CONF_ADDR_W'(N_UNITS * N_FIELDS);

   // memory region is the upper half of the address space
   localparam int                     MEM_ADDR_W    = 3;
   localparam logic [CONF_ADDR_W-1:0] CONF_MEM_BASE = CONF_ADDR_W'(1 << (CONF_ADDR_W - 1));

   // one functional unit
   typedef struct packed {
      // operand a source
      logic [SEL_W-1:0]   sel_a;
      // operand b source
      logic [SEL_W-1:0]   sel_b;
      logic [FNS_W-1:0]   fns;
      // start delay
      logic [DELAY_W-1:0] delay;
   } unit_conf_t;

   // full engine configuration, unit 0 in the low bits
   typedef unit_conf_t [N_UNITS-1:0] conf_word_t;

endpackage

// File: src/conf_reg.sv
`timescale 1ns/1ns

module conf_reg (
   input  logic                            clk,
   input  logic                            rst_n,

   // control bus already decoded to the register region
   input  logic                            ctr_valid,
   input  logic                            ctr_we,
   input  logic [conf_pkg::CONF_ADDR_W-1:0] ctr_addr,
   input  logic [conf_pkg::DATA_W-1:0]      ctr_data,

   // whole-word load from the configuration memory
   input  conf_pkg::conf_word_t            conf_in,
   input  logic                            conf_ld,

   // configuration seen by the data engine
   output conf_pkg::conf_word_t            conf_out
);

   import conf_pkg::*;

   logic                   wr_field;
   logic                   wr_clear;
   logic [UNIT_IDX_W-1:0]  unit;
   logic [FIELD_IDX_W-1:0] field;

   conf_word_t conf_q;
   conf_word_t conf_nxt;

   // request kind
   assign wr_field = ctr_valid & ctr_we & (ctr_addr < CONF_CLEAR);
   assign wr_clear = ctr_valid & ctr_we & (ctr_addr == CONF_CLEAR);

   // split field address into unit and field
   assign field = ctr_addr[FIELD_IDX_W-1:0];
   assign unit  = ctr_addr[FIELD_IDX_W +: UNIT_IDX_W];

   // next configuration
   // load goes first and a field write then overrides its own field
   // while a clear wins over both
   always_comb begin
      conf_nxt = conf_q;

      if (conf_ld) begin
         conf_nxt = conf_in;
      end

      if (wr_field) begin
         case (field)
            FLD_SEL_A: conf_nxt[unit].sel_a = ctr_data[SEL_W-1:0];
            FLD_SEL_B: conf_nxt[unit].sel_b = ctr_data[SEL_W-1:0];
            FLD_FNS:   conf_nxt[unit].fns   = ctr_data[FNS_W-1:0];
            FLD_DELAY: conf_nxt[unit].delay = ctr_data[DELAY_W-1:0];
         endcase
      end

      if (wr_clear) begin
         conf_nxt = '0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         conf_q <= '0;
      end else begin
         conf_q <= conf_nxt;
      end
   end

   assign conf_out = conf_q;

   // the engine must never see x in its configuration
   // such as from a load of a slot that was never stored
   a_conf_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      !$isunknown(conf_out)
   ) else $error("conf_reg: unknown bits in conf_out %h", conf_out);

endmodule

// File: src/conf_mem.sv
`timescale 1ns/1ns

module conf_mem #(
   parameter int MEM_SLOTS = 8
) (
   input  logic                            clk,
   input  logic                            rst_n,

   // control bus already decoded to the memory region
   input  logic                            ctr_valid,
   input  logic                            ctr_we,
   input  logic [conf_pkg::MEM_ADDR_W-1:0] slot,

   // current register contents to store
   input  conf_pkg::conf_word_t            conf_in,

   // replayed slot and its load strobe
   output conf_pkg::conf_word_t            conf_out,
   output logic                            conf_ld
);

   import conf_pkg::*;

   conf_word_t mem [0:MEM_SLOTS-1];
   conf_word_t rd_q;
   logic       ld_q;
   logic       store;
   logic       load;

   assign store = ctr_valid & ctr_we;
   assign load  = ctr_valid & ~ctr_we;

   // slot storage and synchronous read
   always_ff @(posedge clk) begin
      if (store) begin
         mem[slot] <= conf_in;
      end
      if (load) begin
         rd_q <= mem[slot];
      end
   end

   // load strobe lines up with the registered read data
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ld_q <= 1'b0;
      end else begin
         ld_q <= load;
      end
   end

   assign conf_out = rd_q;
   assign conf_ld  = ld_q;

   // exactly one strobe in the cycle after each read request on the bus
   a_ld_timing: assert property (
      @(posedge clk) disable iff (!rst_n)
      conf_ld == $past(ctr_valid && !ctr_we)
   ) else $error("conf_mem: conf_ld out of step with load request");

endmodule

// File: src/conf_ctrl.sv
`timescale 1ns/1ns

module conf_ctrl #(
   parameter int MEM_SLOTS = 8
) (
   input  logic                             clk,
   input  logic                             rst_n,

   // control bus
   input  logic                             ctr_valid,
   input  logic                             ctr_we,
   input  logic [conf_pkg::CONF_ADDR_W-1:0] ctr_addr,
   input  logic [conf_pkg::DATA_W-1:0]      ctr_data,

   // configuration to the data engine
   output conf_pkg::conf_word_t             conf_out,
   output logic                             unmapped
);

   import conf_pkg::*;

   logic                   reg_valid;
   logic                   mem_valid;
   logic                   mem_hit;
   logic [CONF_ADDR_W-1:0] mem_off;

   conf_word_t mem_conf;
   logic       mem_ld;

   // slot offset inside the memory region
   assign mem_off = ctr_addr - CONF_MEM_BASE;
   assign mem_hit = (ctr_addr >= CONF_MEM_BASE) && (mem_off < CONF_ADDR_W'(MEM_SLOTS));

   // address decoder, register region has priority
   always_comb begin
      reg_valid = 1'b0;
      mem_valid = 1'b0;
      unmapped  = 1'b0;
      if (ctr_addr <= CONF_CLEAR) begin
         reg_valid = ctr_valid;
      end else if (mem_hit) begin
         mem_valid = ctr_valid;
      end else begin
         // stray request, flagged for one cycle
         unmapped = ctr_valid;
      end
   end

   conf_reg conf_reg_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctr_valid (reg_valid),
      .ctr_we    (ctr_we),
      .ctr_addr  (ctr_addr),
      .ctr_data  (ctr_data),
      .conf_in   (mem_conf),
      .conf_ld   (mem_ld),
      .conf_out  (conf_out)
   );

   conf_mem #(
      .MEM_SLOTS (MEM_SLOTS)
   ) conf_mem_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctr_valid (mem_valid),
      .ctr_we    (ctr_we),
      .slot      (mem_off[MEM_ADDR_W-1:0]),
      .conf_in   (conf_out),
      .conf_out  (mem_conf),
      .conf_ld   (mem_ld)
   );

   // one target per request
   a_one_target: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(reg_valid && mem_valid)
   ) else $error("conf_ctrl: register and memory selected together");

   // a stray request never reaches the register
   a_unmapped_quiet: assert property (
      @(posedge clk) disable iff (!rst_n)
      (unmapped && !mem_ld) |=> $stable(conf_out)
   ) else $error("conf_ctrl: unmapped request changed conf_out");

endmodule

// File: tests/conf_tb.sv
`timescale 1ns/1ns

module conf_tb #(
   parameter int MEM_SLOTS = 8
);

   import conf_pkg::*;

   localparam int UNIT_BITS   = SEL_W + SEL_W + FNS_W + DELAY_W;
   localparam int CONF_BITS   = N_UNITS * UNIT_BITS;
   localparam int FIELD_ADDRS = N_UNITS * N_FIELDS;
   localparam int LD_TIMEOUT  = 8;

   localparam int REGION_REG  = 0;
   localparam int REGION_MEM  = 1;
   localparam int REGION_NONE = 2;

   logic                   clk;
   logic                   rst_n;
   logic                   ctr_valid;
   logic                   ctr_we;
   logic [CONF_ADDR_W-1:0] ctr_addr;
   logic [DATA_W-1:0]      ctr_data;
   conf_word_t             conf_out;
   logic                   unmapped;

   // reference model, flat word with unit 0 in the low bits
   logic [CONF_BITS-1:0] ref_conf = '0;
   logic [CONF_BITS-1:0] ref_rd   = '0;
   logic [CONF_BITS-1:0] ref_mem [0:MEM_SLOTS-1];
   logic                 ref_ld   = 1'b0;
   logic                 exp_unmapped;

   int seed      = 32'hfb3aae5f;
   int fail_cnt  = 0;
   int test_cnt  = 0;
   bit timed_out = 1'b0;

   conf_ctrl #(
      .MEM_SLOTS (MEM_SLOTS)
   ) conf_ctrl_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctr_valid (ctr_valid),
      .ctr_we    (ctr_we),
      .ctr_addr  (ctr_addr),
      .ctr_data  (ctr_data),
      .conf_out  (conf_out),
      .unmapped  (unmapped)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // lsb of a field inside one unit, sel_a on top
   function automatic int field_lsb(input int field);
      case (field)
         0:       return DELAY_W + FNS_W + SEL_W;
         1:       return DELAY_W + FNS_W;
         2:       return DELAY_W;
         default: return 0;
      endcase
   endfunction

   function automatic int field_width(input int field);
      case (field)
         0, 1:    return SEL_W;
         2:       return FNS_W;
         default: return DELAY_W;
      endcase
   endfunction

   function automatic int region_of(input int addr);
      if (addr <= FIELD_ADDRS) begin
         return REGION_REG;
      end
      if (addr >= int'(CONF_MEM_BASE) && addr < int'(CONF_MEM_BASE) + MEM_SLOTS) begin
         return REGION_MEM;
      end
      return REGION_NONE;
   endfunction

   function automatic logic [CONF_BITS-1:0] put_field(
      input logic [CONF_BITS-1:0] word,
      input int                   addr,
      input logic [DATA_W-1:0]    data
   );
      logic [CONF_BITS-1:0] res;
      int                   base;
      res  = word;
      base = (addr / N_FIELDS) * UNIT_BITS + field_lsb(addr % N_FIELDS);
      // only the field's width is taken from the data word
      for (int i = 0; i < field_width(addr % N_FIELDS); i++) begin
         res[base + i] = data[i];
      end
      return res;
   endfunction

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed) & 32'h7fffffff;
      return r % n;
   endfunction

   assign exp_unmapped = ctr_valid && (region_of(int'(ctr_addr)) == REGION_NONE);

   always @(posedge clk or negedge rst_n) begin : model_update
      logic [CONF_BITS-1:0] nxt;
      int                   region;
      int                   addr;
      if (!rst_n) begin
         ref_conf <= '0;
         ref_ld   <= 1'b0;
      end else begin
         addr   = int'(ctr_addr);
         region = region_of(addr);
         nxt    = ref_conf;
         // pending load lands first, then the write on top
         if (ref_ld) begin
            nxt = ref_rd;
         end
         if (ctr_valid && ctr_we && region == REGION_REG) begin
            if (addr == FIELD_ADDRS) begin
               nxt = '0;
            end else begin
               nxt = put_field(nxt, addr, ctr_data);
            end
         end
         ref_ld <= ctr_valid && !ctr_we && region == REGION_MEM;
         if (ctr_valid && region == REGION_MEM) begin
            if (ctr_we) begin
               ref_mem[addr - int'(CONF_MEM_BASE)] <= ref_conf;
            end else begin
               ref_rd <= ref_mem[addr - int'(CONF_MEM_BASE)];
            end
         end
         ref_conf <= nxt;
      end
   end

   a_conf_match: assert property (
      @(posedge clk) disable iff (!rst_n)
      conf_out == ref_conf
   ) else begin
      fail_cnt++;
      $display("Fail conf_out: got %h, expected %h", $sampled(conf_out), $sampled(ref_conf));
   end

   a_unmapped_match: assert property (
      @(posedge clk) disable iff (!rst_n)
      unmapped == exp_unmapped
   ) else begin
      fail_cnt++;
      $display("Fail unmapped: got %h, expected %h", $sampled(unmapped),
               $sampled(exp_unmapped));
   end

   a_ld_match: assert property (
      @(posedge clk) disable iff (!rst_n)
      conf_ctrl_i.mem_ld == ref_ld
   ) else begin
      fail_cnt++;
      $display("Fail conf_ld: got %h, expected %h", $sampled(conf_ctrl_i.mem_ld),
               $sampled(ref_ld));
   end

   // one request, held for one clock from a falling edge
   task automatic send_request(input logic we, input int addr, input logic [DATA_W-1:0] data);
      ctr_valid = 1'b1;
      ctr_we    = we;
      ctr_addr  = CONF_ADDR_W'(addr);
      ctr_data  = data;
      @(negedge clk);
      ctr_valid = 1'b0;
      ctr_we    = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic fill_random(input int n);
      for (int i = 0; i < n; i++) begin
         send_request(1'b1, rand_below(FIELD_ADDRS), $random(seed));
      end
   endtask

   task automatic wait_load;
      int cycles;
      cycles = 0;
      while (conf_ctrl_i.mem_ld !== 1'b1 && cycles < LD_TIMEOUT && !timed_out) begin
         @(negedge clk);
         cycles++;
      end
      if (conf_ctrl_i.mem_ld !== 1'b1 && !timed_out) begin
         timed_out = 1'b1;
         $display("Timeout: no load strobe came from the configuration memory");
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_cnt++;
      $display("test %s done, %0d errors", name, fail_cnt - errs_before);
   endtask

   initial begin : main_seq
      int errs;
      int slot;
      rst_n     = 1'b0;
      ctr_valid = 1'b0;
      ctr_we    = 1'b0;
      ctr_addr  = '0;
      ctr_data  = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      errs = fail_cnt;
      idle(4);
      report_test("reset_state", errs);

      errs = fail_cnt;
      for (int pass = 0; pass < 2; pass++) begin
         for (int a = 0; a < FIELD_ADDRS; a++) begin
            send_request(1'b1, a, $random(seed));
         end
      end
      idle(1);
      report_test("field_writes", errs);

      errs = fail_cnt;
      fill_random(8);
      send_request(1'b1, FIELD_ADDRS, $random(seed));
      idle(1);
      fill_random(4);
      // clear with we low is a no-op
      send_request(1'b0, FIELD_ADDRS, $random(seed));
      idle(1);
      report_test("clear", errs);

      errs = fail_cnt;
      for (int r = 0; r < 6; r++) begin
         slot = rand_below(MEM_SLOTS);
         fill_random(4);
         send_request(1'b1, int'(CONF_MEM_BASE) + slot, '0);
         fill_random(6);
         send_request(1'b0, int'(CONF_MEM_BASE) + slot, '0);
         wait_load();
         idle(2);
      end
      report_test("store_load", errs);

      errs = fail_cnt;
      for (int r = 0; r < 5; r++) begin
         slot = rand_below(MEM_SLOTS);
         fill_random(4);
         send_request(1'b1, int'(CONF_MEM_BASE) + slot, '0);
         fill_random(4);
         send_request(1'b0, int'(CONF_MEM_BASE) + slot, '0);
         wait_load();
         // write lands in the strobe cycle, last round clears instead
         if (r == 4) begin
            send_request(1'b1, FIELD_ADDRS, $random(seed));
         end else begin
            send_request(1'b1, rand_below(FIELD_ADDRS), $random(seed));
         end
         idle(2);
      end
      report_test("load_override", errs);

      errs = fail_cnt;
      fill_random(4);
      for (int a = FIELD_ADDRS + 1; a < int'(CONF_MEM_BASE); a++) begin
         send_request(rand_below(2) == 1, a, $random(seed));
      end
      for (int a = int'(CONF_MEM_BASE) + MEM_SLOTS; a < 2 ** CONF_ADDR_W; a++) begin
         send_request(rand_below(2) == 1, a, $random(seed));
      end
      for (int i = 0; i < 6; i++) begin
         send_request(1'b0, rand_below(FIELD_ADDRS), $random(seed));
      end
      idle(2);
      report_test("unmapped", errs);

      idle(3);
      $display("tests run: %0d, failed checks: %0d, timeouts: %0d", test_cnt, fail_cnt,
               timed_out);
      if (fail_cnt == 0 && !timed_out) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: files.f
src/conf_pkg.sv
src/conf_reg.sv
src/conf_mem.sv
src/conf_ctrl.sv
tests/conf_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with the default slot count and with a reduced one, runs both
rm -rf obj_dir_full obj_dir_small sim.log
verilator --binary --timing --assert -Wno-fatal --top-module conf_tb -f files.f \
   --Mdir obj_dir_full -o conf_tb_sim &&
verilator --binary --timing --assert -Wno-fatal --top-module conf_tb -f files.f \
   -GMEM_SLOTS=5 --Mdir obj_dir_small -o conf_tb_sim &&
./obj_dir_full/conf_tb_sim > sim.log 2>&1 &&
./obj_dir_small/conf_tb_sim >> sim.log 2>&1 &&
! grep -q "Regression failed" sim.log || {
   echo "simulation failed, see sim.log"
   exit 1
}
